// ==== aluPkg.sv ====
// ALU shared definitions
`default_nettype none

package aluPkg;

    // Opcodes
    typedef enum logic [2:0] {
        ADD8  = 3'd0,
        SUB8  = 3'd1,
        ADD16 = 3'd2,
        SUB16 = 3'd3,
        AND8  = 3'd4,
        OR8   = 3'd5,
        XOR8  = 3'd6,
        CMP16 = 3'd7
    } aluOp;

    // Datapath widths
    localparam int DataWidth = 16;
    localparam int ByteWidth = 8;

    localparam int FlagCount = 7;

    // Logic unit select codes
    localparam logic [1:0] LogicArith = 2'd0;
    localparam logic [1:0] LogicAnd   = 2'd1;
    localparam logic [1:0] LogicOr    = 2'd2;
    localparam logic [1:0] LogicXor   = 2'd3;

    // Flag bit positions
    localparam int FlagCarry          = 0;
    localparam int FlagParityOverflow = 1;
    localparam int FlagHalfCarry      = 2;
    localparam int FlagZero           = 3;
    localparam int FlagSign           = 4;
    localparam int FlagEqual8         = 5;
    localparam int FlagEqual16        = 6;

endpackage

`default_nettype wire

// ==== aluDecode.sv ====
// ALU decode stage
`timescale 1ns/1ps
`default_nettype none

module aluDecode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  aluPkg::aluOp                 op,
    input  logic [aluPkg::DataWidth-1:0] operandA,
    input  logic [aluPkg::DataWidth-1:0] operandB,
    output logic                         opValid,
    output logic [aluPkg::DataWidth-1:0] opA,
    output logic [aluPkg::DataWidth-1:0] opB,
    output logic                         wide,
    output logic                         subtract,
    output logic [1:0]                   logicSel,
    output logic                         parityMode,
    output logic                         keepResult
);

    logic       wideNext;
    logic       subtractNext;
    logic [1:0] logicSelNext;
    logic       keepNext;

    // Opcode expansion
    always_comb begin
        wideNext     = 1'b0;
        subtractNext = 1'b0;
        logicSelNext = aluPkg::LogicArith;
        keepNext     = 1'b1;
        case (op)
            aluPkg::SUB8: begin
                subtractNext = 1'b1;
            end
            aluPkg::ADD16: begin
                wideNext = 1'b1;
            end
            aluPkg::SUB16: begin
                wideNext     = 1'b1;
                subtractNext = 1'b1;
            end
            aluPkg::AND8: begin
                logicSelNext = aluPkg::LogicAnd;
            end
            aluPkg::OR8: begin
                logicSelNext = aluPkg::LogicOr;
            end
            aluPkg::XOR8: begin
                logicSelNext = aluPkg::LogicXor;
            end
            aluPkg::CMP16: begin
                wideNext     = 1'b1;
                subtractNext = 1'b1;
                keepNext     = 1'b0;
            end
            default: begin
                // ADD8 keeps the defaults
                wideNext = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opValid    <= 1'b0;
            wide       <= 1'b0;
            subtract   <= 1'b0;
            logicSel   <= aluPkg::LogicArith;
            parityMode <= 1'b0;
            keepResult <= 1'b0;
        end else begin
            opValid <= start;
            if (start) begin
                wide       <= wideNext;
                subtract   <= subtractNext;
                logicSel   <= logicSelNext;
                parityMode <= (logicSelNext != aluPkg::LogicArith);
                keepResult <= keepNext;
            end
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (start) begin
            opA <= operandA;
            opB <= operandB;
        end
    end

    // Logic ops never reach the adder as a subtraction
    assert property (@(posedge clk) disable iff (rst)
        opValid && (logicSel != aluPkg::LogicArith) |-> !subtract);

endmodule

`default_nettype wire

// ==== aluExecute.sv ====
// ALU execute stage
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
    input  logic [aluPkg::DataWidth-1:0] opA,
    input  logic [aluPkg::DataWidth-1:0] opB,
    input  logic                         wide,
    input  logic                         subtract,
    input  logic [1:0]                   logicSel,
    input  logic                         keepResult,
    output logic [aluPkg::DataWidth-1:0] procB,
    output logic [aluPkg::DataWidth-1:0] rawResult,
    output logic [aluPkg::DataWidth-1:0] sumResult,
    output logic                         carryOut8,
    output logic                         carryOut16
);

    localparam int DW = aluPkg::DataWidth;
    localparam int BW = aluPkg::ByteWidth;

    logic [DW:0]   sum;
    logic [DW-1:0] arithWord;
    logic [BW-1:0] logicByte;

    // Subtraction is A + ~B + 1
    assign procB = subtract ? ~opB : opB;
    assign sum   = {1'b0, opA} + {1'b0, procB} + {{DW{1'b0}}, subtract};

    assign carryOut16 = sum[DW];
    // Carry into bit 8 recovered from the sum bit
    assign carryOut8  = sum[BW] ^ opA[BW] ^ procB[BW];

    assign arithWord = wide ? sum[DW-1:0] : {{(DW-BW){1'b0}}, sum[BW-1:0]};

    // Byte logic unit
    always_comb begin
        case (logicSel)
            aluPkg::LogicAnd: begin
                logicByte = opA[BW-1:0] & opB[BW-1:0];
            end
            aluPkg::LogicOr: begin
                logicByte = opA[BW-1:0] | opB[BW-1:0];
            end
            aluPkg::LogicXor: begin
                logicByte = opA[BW-1:0] ^ opB[BW-1:0];
            end
            default: begin
                logicByte = '0;
            end
        endcase
    end

    assign sumResult = (logicSel == aluPkg::LogicArith) ? arithWord
                                                        : {{(DW-BW){1'b0}}, logicByte};

    // Compare discards the difference
    assign rawResult = keepResult ? sumResult : '0;

endmodule

`default_nettype wire

// ==== aluFlag.sv ====
// ALU flag logic
`timescale 1ns/1ps
`default_nettype none

module aluFlag (
    input  logic [aluPkg::DataWidth-1:0] opA,
    input  logic [aluPkg::DataWidth-1:0] procB,
    input  logic [aluPkg::DataWidth-1:0] rawResult,
    input  logic [aluPkg::DataWidth-1:0] sumResult,
    input  logic                         carryOut8,
    input  logic                         carryOut16,
    input  logic                         wide,
    input  logic                         subtract,
    input  logic [1:0]                   logicSel,
    input  logic                         parityMode,
    output logic [aluPkg::FlagCount-1:0] flagsNext
);

    localparam int DW = aluPkg::DataWidth;
    localparam int BW = aluPkg::ByteWidth;

    logic [DW-1:0] trueB;
    logic          isLogic;
    logic          equal8;
    logic          equal16;
    logic          zeroLow;
    logic          zeroHigh;
    logic          overflow8;
    logic          overflow16;
    logic          parityEven;
    logic          halfCarry;
    logic          carry;

    // Same operand signs, result sign flipped
    function automatic logic overflowAt(input logic a, input logic b, input logic r);
        overflowAt = (a == b) && (r != a);
    endfunction

    assign isLogic = (logicSel != aluPkg::LogicArith);

    // Operand equality on the uninverted second operand
    assign trueB   = subtract ? ~procB : procB;
    assign equal8  = (opA[BW-1:0] == trueB[BW-1:0]);
    assign equal16 = equal8 && (opA[DW-1:BW] == trueB[DW-1:BW]);

    // Zero per byte
    assign zeroLow  = (sumResult[BW-1:0] == '0);
    assign zeroHigh = (sumResult[DW-1:BW] == '0);

    assign overflow8  = overflowAt(opA[BW-1], procB[BW-1], sumResult[BW-1]);
    assign overflow16 = overflowAt(opA[DW-1], procB[DW-1], sumResult[DW-1]);

    assign parityEven = ~^rawResult[BW-1:0];

    // Half carry out of bit 3, for decimal adjust
    assign halfCarry = !isLogic && (opA[4] ^ procB[4] ^ rawResult[4]);

    // Borrow is the inverted carry
    assign carry = !isLogic && ((wide ? carryOut16 : carryOut8) ^ subtract);

    always_comb begin
        flagsNext                             = '0;
        flagsNext[aluPkg::FlagCarry]          = carry;
        flagsNext[aluPkg::FlagParityOverflow] = parityMode ? parityEven
                                                           : (wide ? overflow16 : overflow8);
        flagsNext[aluPkg::FlagHalfCarry]      = halfCarry;
        flagsNext[aluPkg::FlagZero]           = wide ? (zeroLow && zeroHigh) : zeroLow;
        flagsNext[aluPkg::FlagSign]           = wide ? sumResult[DW-1] : sumResult[BW-1];
        flagsNext[aluPkg::FlagEqual8]         = equal8;
        flagsNext[aluPkg::FlagEqual16]        = equal16;
    end

endmodule

`default_nettype wire

// ==== aluResult.sv ====
// ALU result register
`timescale 1ns/1ps
`default_nettype none

module aluResult (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         opValid,
    input  logic [aluPkg::DataWidth-1:0] rawResult,
    input  logic [aluPkg::FlagCount-1:0] flagsNext,
    output logic                         done,
    output logic [aluPkg::DataWidth-1:0] result,
    output logic [aluPkg::FlagCount-1:0] flags
);

    always_ff @(posedge clk) begin
        if (rst) begin
            done   <= 1'b0;
            result <= '0;
            flags  <= '0;
        end else begin
            done <= opValid;
            // Hold until the next operation lands
            if (opValid) begin
                result <= rawResult;
                flags  <= flagsNext;
            end
        end
    end

    // Back-to-back done only for back-to-back operations
    assert property (@(posedge clk) disable iff (rst)
        done && $past(done) |-> $past(opValid) && $past(opValid, 2));

endmodule

`default_nettype wire

// ==== aluCore.sv ====
// Two-stage ALU top
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  aluPkg::aluOp                 op,
    input  logic [aluPkg::DataWidth-1:0] operandA,
    input  logic [aluPkg::DataWidth-1:0] operandB,
    output logic                         done,
    output logic [aluPkg::DataWidth-1:0] result,
    output logic [aluPkg::FlagCount-1:0] flags
);

    logic                         opValid;
    logic [aluPkg::DataWidth-1:0] opA;
    logic [aluPkg::DataWidth-1:0] opB;
    logic                         wide;
    logic                         subtract;
    logic [1:0]                   logicSel;
    logic                         parityMode;
    logic                         keepResult;
    logic [aluPkg::DataWidth-1:0] procB;
    logic [aluPkg::DataWidth-1:0] rawResult;
    logic [aluPkg::DataWidth-1:0] sumResult;
    logic                         carryOut8;
    logic                         carryOut16;
    logic [aluPkg::FlagCount-1:0] flagsNext;

    aluDecode u_decode (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .operandA   (operandA),
        .operandB   (operandB),
        .opValid    (opValid),
        .opA        (opA),
        .opB        (opB),
        .wide       (wide),
        .subtract   (subtract),
        .logicSel   (logicSel),
        .parityMode (parityMode),
        .keepResult (keepResult)
    );

    aluExecute u_execute (
        .opA        (opA),
        .opB        (opB),
        .wide       (wide),
        .subtract   (subtract),
        .logicSel   (logicSel),
        .keepResult (keepResult),
        .procB      (procB),
        .rawResult  (rawResult),
        .sumResult  (sumResult),
        .carryOut8  (carryOut8),
        .carryOut16 (carryOut16)
    );

    aluFlag u_flag (
        .opA        (opA),
        .procB      (procB),
        .rawResult  (rawResult),
        .sumResult  (sumResult),
        .carryOut8  (carryOut8),
        .carryOut16 (carryOut16),
        .wide       (wide),
        .subtract   (subtract),
        .logicSel   (logicSel),
        .parityMode (parityMode),
        .flagsNext  (flagsNext)
    );

    aluResult u_result (
        .clk       (clk),
        .rst       (rst),
        .opValid   (opValid),
        .rawResult (rawResult),
        .flagsNext (flagsNext),
        .done      (done),
        .result    (result),
        .flags     (flags)
    );

endmodule

`default_nettype wire

// ==== tbAluCore.sv ====
// ALU core testbench
`timescale 1ns/1ps
`default_nettype none

module tbAluCore;

    logic                         clk;
    logic                         rst;
    logic                         start;
    aluPkg::aluOp                 opIn;
    logic [aluPkg::DataWidth-1:0] operandA;
    logic [aluPkg::DataWidth-1:0] operandB;
    logic                         done;
    logic [aluPkg::DataWidth-1:0] result;
    logic [aluPkg::FlagCount-1:0] flags;

    // Expected entries, one per start, in issue order
    logic [15:0] resQ[$];
    logic [6:0]  flgQ[$];
    int          dueQ[$];
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          testErrors = 0;
    integer      seed;

    aluCore u_dut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (opIn),
        .operandA (operandA),
        .operandB (operandB),
        .done     (done),
        .result   (result),
        .flags    (flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Reference model from the flag rules
    task automatic predict(input aluPkg::aluOp op, input logic [15:0] a, input logic [15:0] b,
                           output logic [15:0] res, output logic [6:0] flg);
        logic        isWide;
        logic        isSub;
        logic        isLogic;
        logic [15:0] pb;
        logic [16:0] full;
        logic [8:0]  low;
        logic [15:0] sum;
        int          msb;
        isWide  = (op == aluPkg::ADD16) || (op == aluPkg::SUB16) || (op == aluPkg::CMP16);
        isSub   = (op == aluPkg::SUB8) || (op == aluPkg::SUB16) || (op == aluPkg::CMP16);
        isLogic = (op == aluPkg::AND8) || (op == aluPkg::OR8) || (op == aluPkg::XOR8);
        pb      = isSub ? ~b : b;
        full    = {1'b0, a} + {1'b0, pb} + {16'b0, isSub};
        low     = {1'b0, a[7:0]} + {1'b0, pb[7:0]} + {8'b0, isSub};
        msb     = isWide ? 15 : 7;
        case (op)
            aluPkg::AND8: sum = {8'h00, a[7:0] & b[7:0]};
            aluPkg::OR8:  sum = {8'h00, a[7:0] | b[7:0]};
            aluPkg::XOR8: sum = {8'h00, a[7:0] ^ b[7:0]};
            default:      sum = isWide ? full[15:0] : {8'h00, low[7:0]};
        endcase
        // Compare throws the difference away but keeps its flags
        res = (op == aluPkg::CMP16) ? 16'h0000 : sum;
        flg = '0;
        flg[aluPkg::FlagCarry]     = !isLogic && ((isWide ? full[16] : low[8]) ^ isSub);
        flg[aluPkg::FlagHalfCarry] = !isLogic && (a[4] ^ pb[4] ^ res[4]);
        flg[aluPkg::FlagZero]      = isWide ? (sum == 16'h0000) : (sum[7:0] == 8'h00);
        flg[aluPkg::FlagSign]      = sum[msb];
        flg[aluPkg::FlagParityOverflow] = isLogic ? ~^res[7:0]
                                                  : (a[msb] == pb[msb]) && (sum[msb] != a[msb]);
        flg[aluPkg::FlagEqual8]    = (a[7:0] == b[7:0]);
        flg[aluPkg::FlagEqual16]   = (a == b);
    endtask

    // Match every done against the oldest expected entry
    always @(negedge clk) begin
        if (!rst) begin
            if (done) begin
                checks++;
                assert (dueQ.size() > 0) else begin
                    $display("Done was raised with no operation in flight");
                    errors++;
                end
                if (dueQ.size() > 0) begin
                    assert (dueQ[0] == cycle) else begin
                        $display("Done arrived at cycle %0d instead of %0d", cycle, dueQ[0]);
                        errors++;
                    end
                    assert (result == resQ[0]) else begin
                        $display("ERROR at %0t: result %h, expected %h", $time, result, resQ[0]);
                        errors++;
                    end
                    assert (flags == flgQ[0]) else begin
                        $display("ERROR at %0t: flags %b, expected %b", $time, flags, flgQ[0]);
                        errors++;
                    end
                    void'(resQ.pop_front());
                    void'(flgQ.pop_front());
                    void'(dueQ.pop_front());
                end
            end else if (dueQ.size() > 0) begin
                assert (dueQ[0] > cycle) else begin
                    $display("Done never came for the operation due at cycle %0d", dueQ[0]);
                    errors++;
                    void'(resQ.pop_front());
                    void'(flgQ.pop_front());
                    void'(dueQ.pop_front());
                end
            end
        end
    end

    task automatic issue(input aluPkg::aluOp op, input logic [15:0] a, input logic [15:0] b);
        logic [15:0] res;
        logic [6:0]  flg;
        @(negedge clk);
        predict(op, a, b, res, flg);
        start    = 1'b1;
        opIn     = op;
        operandA = a;
        operandB = b;
        resQ.push_back(res);
        flgQ.push_back(flg);
        dueQ.push_back(cycle + 2);
    endtask

    task automatic idle();
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (dueQ.size() > 0 && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (dueQ.size() > 0) begin
            $display("Timed out waiting for done");
            errors++;
            resQ.delete();
            flgQ.delete();
            dueQ.delete();
        end
    endtask

    task automatic expectFlag(input int pos, input logic value, input string what);
        checks++;
        assert (flags[pos] == value) else begin
            $display("ERROR at %0t: %s flag is %b, expected %b", $time, what, flags[pos], value);
            errors++;
        end
    endtask

    task automatic finishTest(input string name);
        $display("%s finished with %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    function automatic aluPkg::aluOp opFromIndex(input int i);
        case (i % 8)
            0: opFromIndex = aluPkg::ADD8;
            1: opFromIndex = aluPkg::SUB8;
            2: opFromIndex = aluPkg::ADD16;
            3: opFromIndex = aluPkg::SUB16;
            4: opFromIndex = aluPkg::AND8;
            5: opFromIndex = aluPkg::OR8;
            6: opFromIndex = aluPkg::XOR8;
            default: opFromIndex = aluPkg::CMP16;
        endcase
    endfunction

    initial begin
        int          i;
        logic [15:0] a;
        logic [15:0] b;
        seed     = 32'h1492_c589;
        rst      = 1'b1;
        start    = 1'b0;
        opIn     = aluPkg::ADD8;
        operandA = '0;
        operandB = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        checks++;
        assert (result == '0 && flags == '0 && !done) else begin
            $display("ERROR at %0t: outputs not cleared by reset", $time);
            errors++;
        end
        repeat (4) @(negedge clk);
        for (i = 0; i < 3; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue(aluPkg::ADD8, a, b);
            idle();
            waitDrain();
        end
        finishTest("Latency and reset");

        for (i = 0; i < 40; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue(opFromIndex(i % 4), a, b);
            idle();
            waitDrain();
        end
        issue(aluPkg::ADD8, 16'h007F, 16'h0001);
        idle();
        waitDrain();
        expectFlag(aluPkg::FlagParityOverflow, 1'b1, "8-bit overflow");
        issue(aluPkg::SUB16, 16'h8000, 16'h0001);
        idle();
        waitDrain();
        expectFlag(aluPkg::FlagParityOverflow, 1'b1, "16-bit overflow");
        finishTest("Arithmetic");

        for (i = 0; i < 24; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue(opFromIndex(4 + i % 3), a, b);
            idle();
            waitDrain();
        end
        finishTest("Logic");

        issue(aluPkg::CMP16, 16'hA55A, 16'hA55A);
        idle();
        waitDrain();
        expectFlag(aluPkg::FlagEqual16, 1'b1, "Equal16 on equal operands");
        issue(aluPkg::CMP16, 16'h1234, 16'h5634);
        idle();
        waitDrain();
        expectFlag(aluPkg::FlagEqual8, 1'b1, "Equal8 on upper byte mismatch");
        expectFlag(aluPkg::FlagEqual16, 1'b0, "Equal16 on upper byte mismatch");
        for (i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue(aluPkg::CMP16, a, b);
            idle();
            waitDrain();
        end
        finishTest("Compare");

        // Two operations in flight every cycle
        for (i = 0; i < 32; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue(opFromIndex(i * 3), a, b);
        end
        idle();
        waitDrain();
        finishTest("Back-to-back");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== aluFlagCore.f ====
aluPkg.sv
aluDecode.sv
aluExecute.sv
aluFlag.sv
aluResult.sv
aluCore.sv
tbAluCore.sv
